//--- compile.f
hw/boot_pkg.sv
hw/cfg_loader.sv
hw/nbf_loader.sv
hw/cmd_router.sv
hw/mem_bank.sv
hw/host_mmio.sv
hw/resp_merge.sv
hw/boot_top.sv
verification/tb_boot_top.sv

//--- hw/boot_pkg.sv
// Boot memory subsystem definitions
// Address map, sizes, the configuration table and the command and response formats
package boot_pkg;

   localparam int ADDR_W        = 16;
   localparam int DATA_W        = 32;
   localparam int NUM_BANKS     = 4;
   localparam int BANK_WORDS    = 64;
   localparam int BANK_SEL_LSB  = 6;
   localparam int BANK_W        = $clog2(NUM_BANKS);
   localparam int WORD_W        = $clog2(BANK_WORDS);
   localparam int HOST_ADDR_BIT = 15;
   localparam logic [ADDR_W-1:0] HOST_FINISH_ADDR = 16'h8000;

   localparam int MEM_LATENCY = 3;

   // Width of the outstanding image response counter
   localparam int OUT_CNT_W = 4;

   localparam int CFG_COUNT = 4;
   localparam int CFG_IDX_W = $clog2(CFG_COUNT);

   // One word per bank with entry 0 on the right
   localparam logic [CFG_COUNT-1:0][ADDR_W-1:0] CFG_ADDR =
      {16'h00C0, 16'h0080, 16'h0040, 16'h0000};
   localparam logic [CFG_COUNT-1:0][DATA_W-1:0] CFG_DATA =
      {32'hC0DE_0004, 32'hC0DE_0003, 32'hC0DE_0002, 32'hC0DE_0001};

   typedef enum logic [1:0] {
      OP_READ   = 2'd0,
      OP_WRITE  = 2'd1,
      OP_FINISH = 2'd2
   } op_e;

   typedef enum logic {
      SRC_CFG = 1'b0,
      SRC_NBF = 1'b1
   } src_e;

   typedef struct packed {
      op_e               op;
      src_e              src;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } mem_cmd_s;

   // Data holds read data or zero for writes
   typedef struct packed {
      op_e               op;
      src_e              src;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } mem_resp_s;

endpackage

//--- hw/boot_top.sv
// Boot memory subsystem top level
// Configuration loader, then the image loader, feed a router in front of
// the memory banks and the host block; a merger returns the responses
`timescale 1ns/1ps

module boot_top (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        nbf_v_i,
   input  boot_pkg::mem_cmd_s          nbf_cmd_i,
   output logic                        nbf_ready_o,
   output logic                        cfg_done_o,
   output logic                        nbf_done_o,
   output logic                        resp_v_o,
   output boot_pkg::mem_resp_s         resp_o,
   output logic                        program_finish_o,
   output logic [boot_pkg::DATA_W-1:0] finish_code_o
);

   boot_pkg::mem_cmd_s             cfg_cmd;
   logic                           cfg_cmd_v;
   logic                           cfg_ack;
   boot_pkg::mem_cmd_s             ld_cmd;
   logic                           ld_cmd_v;
   logic                           nbf_ack;
   boot_pkg::mem_cmd_s             rt_cmd;
   logic [boot_pkg::NUM_BANKS-1:0] bank_v;
   logic                           host_v;
   boot_pkg::mem_resp_s            bank_resp [boot_pkg::NUM_BANKS];
   logic [boot_pkg::NUM_BANKS-1:0] bank_resp_v;
   boot_pkg::mem_resp_s            host_resp;
   logic                           host_resp_v;

   cfg_loader u_cfg_loader (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .cmd_o   (cfg_cmd),
      .cmd_v_o (cfg_cmd_v),
      .ack_i   (cfg_ack),
      .done_o  (cfg_done_o)
   );

   nbf_loader u_nbf_loader (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cfg_done_i  (cfg_done_o),
      .nbf_v_i     (nbf_v_i),
      .nbf_cmd_i   (nbf_cmd_i),
      .nbf_ready_o (nbf_ready_o),
      .cmd_o       (ld_cmd),
      .cmd_v_o     (ld_cmd_v),
      .ack_i       (nbf_ack),
      .done_o      (nbf_done_o)
   );

   cmd_router u_cmd_router (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cfg_done_i (cfg_done_o),
      .cfg_cmd_i  (cfg_cmd),
      .cfg_v_i    (cfg_cmd_v),
      .nbf_cmd_i  (ld_cmd),
      .nbf_v_i    (ld_cmd_v),
      .cmd_o      (rt_cmd),
      .bank_v_o   (bank_v),
      .host_v_o   (host_v)
   );

   for (genvar b = 0; b < boot_pkg::NUM_BANKS; b++)
   begin : g_bank
      mem_bank u_mem_bank (
         .clk_i    (clk_i),
         .rst_i    (rst_i),
         .cmd_i    (rt_cmd),
         .cmd_v_i  (bank_v[b]),
         .resp_o   (bank_resp[b]),
         .resp_v_o (bank_resp_v[b])
      );
   end

   host_mmio u_host_mmio (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .cmd_i            (rt_cmd),
      .cmd_v_i          (host_v),
      .resp_o           (host_resp),
      .resp_v_o         (host_resp_v),
      .program_finish_o (program_finish_o),
      .finish_code_o    (finish_code_o)
   );

   resp_merge u_resp_merge (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .bank_resp_i (bank_resp),
      .bank_v_i    (bank_resp_v),
      .host_resp_i (host_resp),
      .host_v_i    (host_resp_v),
      .cfg_ack_o   (cfg_ack),
      .nbf_ack_o   (nbf_ack),
      .resp_o      (resp_o),
      .resp_v_o    (resp_v_o)
   );

endmodule

//--- hw/cfg_loader.sv
// Configuration loader
// Writes the fixed configuration table into memory one word per cycle
// and flags done once every write has been acknowledged
`timescale 1ns/1ps

module cfg_loader (
   input  logic               clk_i,
   input  logic               rst_i,
   output boot_pkg::mem_cmd_s cmd_o,
   output logic               cmd_v_o,
   input  logic               ack_i,
   output logic               done_o
);

   logic [boot_pkg::CFG_IDX_W:0] idx_q;
   logic [boot_pkg::CFG_IDX_W:0] ack_cnt_q;
   logic                         issue;

   assign issue = (int'(idx_q) < boot_pkg::CFG_COUNT);

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         idx_q     <= '0;
         cmd_v_o   <= 1'b0;
         ack_cnt_q <= '0;
         done_o    <= 1'b0;
      end
      else
      begin
         cmd_v_o <= issue;
         if (issue)
            idx_q <= idx_q + 1'b1;
         if (ack_i)
            ack_cnt_q <= ack_cnt_q + 1'b1;
         // Last acknowledgement
         if (ack_i && (int'(ack_cnt_q) == boot_pkg::CFG_COUNT - 1))
            done_o <= 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (issue)
      begin
         cmd_o.op   <= boot_pkg::OP_WRITE;
         cmd_o.src  <= boot_pkg::SRC_CFG;
         cmd_o.addr <= boot_pkg::CFG_ADDR[idx_q[boot_pkg::CFG_IDX_W-1:0]];
         cmd_o.data <= boot_pkg::CFG_DATA[idx_q[boot_pkg::CFG_IDX_W-1:0]];
      end
   end

endmodule

//--- hw/cmd_router.sv
// Command router
// Fixed priority between the two loaders with configuration first
// Decodes the address into one bank valid or the host valid
`timescale 1ns/1ps

module cmd_router (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           cfg_done_i,
   input  boot_pkg::mem_cmd_s             cfg_cmd_i,
   input  logic                           cfg_v_i,
   input  boot_pkg::mem_cmd_s             nbf_cmd_i,
   input  logic                           nbf_v_i,
   output boot_pkg::mem_cmd_s             cmd_o,
   output logic [boot_pkg::NUM_BANKS-1:0] bank_v_o,
   output logic                           host_v_o
);

   logic                         nbf_sel_q;
   logic                         sel_v;
   logic                         to_host;
   logic [boot_pkg::BANK_W-1:0]  bank_sel;

   // Grant moves to the image loader for good once configuration completes
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         nbf_sel_q <= 1'b0;
      else if (cfg_done_i)
         nbf_sel_q <= 1'b1;
   end

   always_comb
   begin
      if (nbf_sel_q)
      begin
         cmd_o = nbf_cmd_i;
         sel_v = nbf_v_i;
      end
      else
      begin
         cmd_o = cfg_cmd_i;
         sel_v = cfg_v_i;
      end
   end

   assign to_host  = cmd_o.addr[boot_pkg::HOST_ADDR_BIT] || (cmd_o.op == boot_pkg::OP_FINISH);
   assign bank_sel = cmd_o.addr[boot_pkg::BANK_SEL_LSB +: boot_pkg::BANK_W];
   assign host_v_o = sel_v && to_host;

   always_comb
   begin
      bank_v_o = '0;
      if (sel_v && !to_host)
         bank_v_o[bank_sel] = 1'b1;
   end

endmodule

//--- hw/host_mmio.sv
// Host MMIO block
// Latches the program-finish flag and code and answers every command
// with zero data after the fixed memory latency
`timescale 1ns/1ps

module host_mmio (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  boot_pkg::mem_cmd_s          cmd_i,
   input  logic                        cmd_v_i,
   output boot_pkg::mem_resp_s         resp_o,
   output logic                        resp_v_o,
   output logic                        program_finish_o,
   output logic [boot_pkg::DATA_W-1:0] finish_code_o
);

   logic                             finish_hit;
   boot_pkg::mem_resp_s              resp_q [boot_pkg::MEM_LATENCY];
   logic [boot_pkg::MEM_LATENCY-1:0] v_q;

   assign finish_hit = cmd_v_i && ((cmd_i.op == boot_pkg::OP_FINISH) ||
      ((cmd_i.op == boot_pkg::OP_WRITE) && (cmd_i.addr == boot_pkg::HOST_FINISH_ADDR)));

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         program_finish_o <= 1'b0;
         finish_code_o    <= '0;
         v_q              <= '0;
      end
      else
      begin
         v_q <= {v_q[boot_pkg::MEM_LATENCY-2:0], cmd_v_i};
         if (finish_hit)
         begin
            program_finish_o <= 1'b1;
            finish_code_o    <= cmd_i.data;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      resp_q[0].op   <= cmd_i.op;
      resp_q[0].src  <= cmd_i.src;
      resp_q[0].addr <= cmd_i.addr;
      resp_q[0].data <= '0;
      for (int i = 1; i < boot_pkg::MEM_LATENCY; i++)
         resp_q[i] <= resp_q[i-1];
   end

   assign resp_o   = resp_q[boot_pkg::MEM_LATENCY-1];
   assign resp_v_o = v_q[boot_pkg::MEM_LATENCY-1];

endmodule

//--- hw/mem_bank.sv
// Memory bank
// Word storage with a fixed-latency response pipeline
// The access happens on the cycle the command arrives
`timescale 1ns/1ps

module mem_bank (
   input  logic                clk_i,
   input  logic                rst_i,
   input  boot_pkg::mem_cmd_s  cmd_i,
   input  logic                cmd_v_i,
   output boot_pkg::mem_resp_s resp_o,
   output logic                resp_v_o
);

   logic [boot_pkg::DATA_W-1:0]      mem_q [boot_pkg::BANK_WORDS];
   logic [boot_pkg::WORD_W-1:0]      word;
   boot_pkg::mem_resp_s              resp_q [boot_pkg::MEM_LATENCY];
   logic [boot_pkg::MEM_LATENCY-1:0] v_q;

   assign word = cmd_i.addr[boot_pkg::WORD_W-1:0];

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         for (int i = 0; i < boot_pkg::BANK_WORDS; i++)
            mem_q[i] <= '0;
         v_q <= '0;
      end
      else
      begin
         v_q <= {v_q[boot_pkg::MEM_LATENCY-2:0], cmd_v_i};
         if (cmd_v_i && (cmd_i.op == boot_pkg::OP_WRITE))
            mem_q[word] <= cmd_i.data;
      end
   end

   always_ff @(posedge clk_i)
   begin
      resp_q[0].op   <= cmd_i.op;
      resp_q[0].src  <= cmd_i.src;
      resp_q[0].addr <= cmd_i.addr;
      resp_q[0].data <= (cmd_i.op == boot_pkg::OP_READ) ? mem_q[word] : '0;
      for (int i = 1; i < boot_pkg::MEM_LATENCY; i++)
         resp_q[i] <= resp_q[i-1];
   end

   assign resp_o   = resp_q[boot_pkg::MEM_LATENCY-1];
   assign resp_v_o = v_q[boot_pkg::MEM_LATENCY-1];

endmodule

//--- hw/nbf_loader.sv
// Program image loader
// Takes image commands from outside once configuration is done, registers
// them for one cycle and tracks the finish marker and outstanding responses
`timescale 1ns/1ps

module nbf_loader (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               cfg_done_i,
   input  logic               nbf_v_i,
   input  boot_pkg::mem_cmd_s nbf_cmd_i,
   output logic               nbf_ready_o,
   output boot_pkg::mem_cmd_s cmd_o,
   output logic               cmd_v_o,
   input  logic               ack_i,
   output logic               done_o
);

   logic                           accept;
   logic                           finish_q;
   logic [boot_pkg::OUT_CNT_W-1:0] out_cnt_q;

   // Closed until configuration is done and again after finish
   assign nbf_ready_o = cfg_done_i && !finish_q;
   assign accept      = nbf_v_i && nbf_ready_o;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         cmd_v_o   <= 1'b0;
         finish_q  <= 1'b0;
         out_cnt_q <= '0;
      end
      else
      begin
         cmd_v_o <= accept;
         if (accept && (nbf_cmd_i.op == boot_pkg::OP_FINISH))
            finish_q <= 1'b1;
         case ({cmd_v_o, ack_i})
            2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
            2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
            default: out_cnt_q <= out_cnt_q;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         cmd_o.op   <= nbf_cmd_i.op;
         cmd_o.src  <= boot_pkg::SRC_NBF;
         cmd_o.addr <= nbf_cmd_i.addr;
         cmd_o.data <= nbf_cmd_i.data;
      end
   end

   // The finish command itself is still counted while it is in the register
   assign done_o = finish_q && !cmd_v_o && (out_cnt_q == '0);

endmodule

//--- hw/resp_merge.sv
// Response merger
// Registers the one valid target response and steers it by source
// Configuration acks stay internal and image responses go out
`timescale 1ns/1ps

module resp_merge (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  boot_pkg::mem_resp_s            bank_resp_i [boot_pkg::NUM_BANKS],
   input  logic [boot_pkg::NUM_BANKS-1:0] bank_v_i,
   input  boot_pkg::mem_resp_s            host_resp_i,
   input  logic                           host_v_i,
   output logic                           cfg_ack_o,
   output logic                           nbf_ack_o,
   output boot_pkg::mem_resp_s            resp_o,
   output logic                           resp_v_o
);

   boot_pkg::mem_resp_s sel_resp;
   boot_pkg::mem_resp_s resp_q;
   logic                resp_v_q;

   // Equal latency and single issue leave at most one source valid
   always_comb
   begin
      sel_resp = host_resp_i;
      for (int i = 0; i < boot_pkg::NUM_BANKS; i++)
      begin
         if (bank_v_i[i])
            sel_resp = bank_resp_i[i];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         resp_v_q <= 1'b0;
      else
         resp_v_q <= host_v_i || (|bank_v_i);
   end

   always_ff @(posedge clk_i)
   begin
      resp_q <= sel_resp;
   end

   assign cfg_ack_o = resp_v_q && (resp_q.src == boot_pkg::SRC_CFG);
   assign nbf_ack_o = resp_v_q && (resp_q.src == boot_pkg::SRC_NBF);
   assign resp_v_o  = nbf_ack_o;
   assign resp_o    = resp_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_boot_top -f compile.f -o tb_boot_top \
   || { echo "Build failed"; exit 1; }
sim_out=$(./obj_dir/tb_boot_top)
echo "$sim_out"
echo "$sim_out" | grep -qx "Result: PASSED" && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

//--- verification/boot_golden.txt
# Columns: test, opcode (0 read, 1 write, 2 finish), address, data, expected
# Expected is the read data, zero for a write and the finish code for a finish
1 0 0000 00000000 c0de0001
1 0 0040 00000000 c0de0002
1 0 0080 00000000 c0de0003
1 0 00c0 00000000 c0de0004
2 1 0005 12345678 00000000
2 0 0005 00000000 12345678
2 0 0006 00000000 00000000
2 1 003f 89abcdef 00000000
2 0 003f 00000000 89abcdef
3 1 0010 11110000 00000000
3 1 0050 22221111 00000000
3 0 0010 00000000 11110000
3 1 0090 33332222 00000000
3 0 0050 00000000 22221111
3 1 00d0 44443333 00000000
3 0 0090 00000000 33332222
3 1 0011 55554444 00000000
3 0 0011 00000000 55554444
3 0 00d0 00000000 44443333
3 0 0005 00000000 12345678
3 0 00c0 00000000 c0de0004
5 1 0020 deadbeef 00000000
5 1 00e0 0badf00d 00000000
5 2 8000 0000002a 0000002a

//--- verification/tb_boot_top.sv
// Testbench for the boot memory subsystem
// Replays the golden command file through the image port and checks
// configuration, bank traffic, random data and program finish
`timescale 1ns/1ps

module tb_boot_top;

   // Loader register, bank pipeline and merge register
   localparam int RESP_LATENCY = 5;
   localparam int WAIT_LIMIT   = 200;

   logic                clk;
   logic                rst;
   logic                nbf_v;
   boot_pkg::mem_cmd_s  nbf_cmd;
   logic                nbf_ready;
   logic                cfg_done;
   logic                nbf_done;
   logic                resp_v;
   boot_pkg::mem_resp_s resp;
   logic                program_finish;
   logic [31:0]         finish_code;

   int          cycle = 0;
   int          errors;
   int          test_errors;
   int          tests_run;
   int          tests_failed;
   int          seed;
   string       test_name;
   logic [31:0] finish_exp;
   int          g_test [$];
   logic [1:0]  g_op [$];
   logic [15:0] g_addr [$];
   logic [31:0] g_data [$];
   logic [31:0] g_exp [$];
   // Responses still expected with the oldest first
   logic [31:0] exp_data [$];
   logic [15:0] exp_addr [$];
   logic [1:0]  exp_op [$];
   int          exp_cycle [$];
   logic [31:0] rand_data [16];

   boot_top u_boot_top (
      .clk_i            (clk),
      .rst_i            (rst),
      .nbf_v_i          (nbf_v),
      .nbf_cmd_i        (nbf_cmd),
      .nbf_ready_o      (nbf_ready),
      .cfg_done_o       (cfg_done),
      .nbf_done_o       (nbf_done),
      .resp_v_o         (resp_v),
      .resp_o           (resp),
      .program_finish_o (program_finish),
      .finish_code_o    (finish_code)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
      cycle <= cycle + 1;

   task automatic check_value(input string what, input logic [31:0] expected,
      input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("CHECK FAILED test %s, %s: expected %h actual %h",
            test_name, what, expected, actual);
         errors = errors + 1;
      end
   endtask

   task automatic abort_wait(input string what);
      $display("Timeout while waiting for %s in test %s", what, test_name);
      $display("Result: FAILED");
      $finish;
   endtask

   // Responses return in issue order and match the oldest entry
   always @(negedge clk)
   begin
      if (resp_v === 1'b1)
      begin
         if (exp_data.size() == 0)
         begin
            $display("Response for address %h arrived with nothing outstanding", resp.addr);
            errors = errors + 1;
         end
         else
         begin
            check_value("response data", exp_data.pop_front(), resp.data);
            check_value("response address", 32'(exp_addr.pop_front()), 32'(resp.addr));
            check_value("response op", 32'(exp_op.pop_front()), 32'(resp.op));
            check_value("response source", 32'(boot_pkg::SRC_NBF), 32'(resp.src));
            check_value("response latency", RESP_LATENCY, cycle - exp_cycle.pop_front());
         end
      end
   end

   task automatic load_golden();
      int                fd;
      int                n;
      int                t;
      logic [8*160-1:0]  line;
      logic [31:0]       op;
      logic [31:0]       addr;
      logic [31:0]       data;
      logic [31:0]       expv;
      fd = $fopen("verification/boot_golden.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the golden file verification/boot_golden.txt");
         $display("Result: FAILED");
         $finish;
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = '0;
            n = $fgets(line, fd);
            // Header and blank lines do not scan as five fields
            if ((n > 0) && ($sscanf(line, "%d %h %h %h %h", t, op, addr, data, expv) == 5))
            begin
               g_test.push_back(t);
               g_op.push_back(op[1:0]);
               g_addr.push_back(addr[15:0]);
               g_data.push_back(data);
               g_exp.push_back(expv);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = errors;
   endtask

   task automatic end_test();
      tests_run = tests_run + 1;
      if (errors == test_errors)
         $display("Test %s finished without errors", test_name);
      else
      begin
         tests_failed = tests_failed + 1;
         $display("Test %s finished with %0d errors", test_name, errors - test_errors);
      end
   endtask

   // Entered on a falling edge and holds valid for one rising edge
   task automatic send_cmd(input logic [1:0] op, input logic [15:0] addr,
      input logic [31:0] data, input logic [31:0] expected);
      int waited;
      waited = 0;
      while (nbf_ready !== 1'b1)
      begin
         @(negedge clk);
         waited = waited + 1;
         if (waited > WAIT_LIMIT)
            abort_wait("nbf_ready_o");
      end
      nbf_v        = 1'b1;
      nbf_cmd.op   = boot_pkg::op_e'(op);
      nbf_cmd.src  = boot_pkg::SRC_NBF;
      nbf_cmd.addr = addr;
      nbf_cmd.data = data;
      exp_data.push_back(expected);
      exp_addr.push_back(addr);
      exp_op.push_back(op);
      exp_cycle.push_back(cycle);
      @(negedge clk);
      nbf_v = 1'b0;
   endtask

   task automatic drain_responses();
      int waited;
      waited = 0;
      while (exp_data.size() != 0)
      begin
         @(negedge clk);
         waited = waited + 1;
         if (waited > WAIT_LIMIT)
            abort_wait("outstanding responses");
      end
   endtask

   // The host answers a finish with zero data and the code goes to finish_code_o
   task automatic run_golden(input int test, input bit serial);
      for (int i = 0; i < g_test.size(); i++)
      begin
         if (g_test[i] == test)
         begin
            if (g_op[i] == 2'd2)
               finish_exp = g_exp[i];
            send_cmd(g_op[i], g_addr[i], g_data[i], (g_op[i] == 2'd2) ? 32'h0 : g_exp[i]);
            if (serial)
               drain_responses();
         end
      end
   endtask

   // Bank from the low index bits and words from 40 up to stay clear of golden addresses
   function automatic logic [15:0] rand_addr(input int i);
      return 16'((i % 4) * 64 + 40 + i);
   endfunction

   initial
   begin
      int waited;
      rst          = 1'b1;
      nbf_v        = 1'b0;
      nbf_cmd      = '0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      finish_exp   = '0;
      seed         = 32'h97f9;
      load_golden();
      repeat (10) @(negedge clk);
      rst = 1'b0;

      start_test("configuration");
      check_value("image ready before configuration", 0, nbf_ready);
      waited = 0;
      while (cfg_done !== 1'b1)
      begin
         @(negedge clk);
         waited = waited + 1;
         if (waited > WAIT_LIMIT)
            abort_wait("cfg_done_o");
      end
      run_golden(1, 1'b1);
      end_test();

      start_test("write then read");
      run_golden(2, 1'b1);
      end_test();

      start_test("back to back");
      run_golden(3, 1'b0);
      drain_responses();
      end_test();

      start_test("random data");
      for (int i = 0; i < 16; i++)
      begin
         rand_data[i] = $random(seed);
         send_cmd(2'd1, rand_addr(i), rand_data[i], 32'h0);
      end
      for (int i = 0; i < 16; i++)
         send_cmd(2'd0, rand_addr(i), 32'h0, rand_data[i]);
      drain_responses();
      end_test();

      start_test("finish");
      check_value("program finish before finish", 0, program_finish);
      run_golden(5, 1'b0);
      check_value("ready after finish", 0, nbf_ready);
      check_value("done while responses outstanding", 0, nbf_done);
      waited = 0;
      while (nbf_done !== 1'b1)
      begin
         @(negedge clk);
         waited = waited + 1;
         if (waited > WAIT_LIMIT)
            abort_wait("nbf_done_o");
      end
      check_value("program finish", 1, program_finish);
      check_value("finish code", finish_exp, finish_code);
      check_value("responses left", 0, exp_data.size());
      end_test();

      $display("Tests run %0d, tests with errors %0d, errors %0d",
         tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule
